// File: bench/fmaTb.sv
`default_nettype none

module fmaTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ne   = fmaPkg::NE;
    localparam int nf   = fmaPkg::NF;
    localparam int oW   = fmaPkg::opW(ne, nf);
    localparam int sW   = fmaPkg::sumW(nf);
    localparam int eW   = fmaPkg::expW(ne);
    localparam int bias = (1 << (ne - 1)) - 1;
    localparam int maxE = (1 << ne) - 1;

    // run length: reset, every operation, pipeline drain per test, margin
    localparam int numTests   = 5;
    localparam int totalOps   = 20 + 16 + 8 + 6 + 30;
    localparam int cycleLimit = 10 + totalOps + 3 * numTests + 50;

    typedef struct packed {
        logic [sW-1:0] m;
        logic [eW-1:0] e;
        logic          s;
    } resultT;

    logic          clk = 1'b0;
    logic          rstN;
    logic          inValid;
    fmaPkg::fmaOp  op;
    logic [oW-1:0] x;
    logic [oW-1:0] y;
    logic [oW-1:0] z;
    logic          outValid;
    logic [sW-1:0] sumM;
    logic [eW-1:0] sumE;
    logic          sticky;

    // expected results in issue order
    resultT expQ[$];
    int     idQ[$];
    integer seed;
    int     opCount     = 0;
    int     errCount    = 0;
    int     checkCount  = 0;
    int     cycleCount  = 0;
    int     testErrBase = 0;
    // inValid as seen at the last three falling edges
    logic [2:0] validHist = '0;

    fmaTop #(.ne(ne), .nf(nf)) u_fmaTop (
        .clk(clk), .rstN(rstN), .inValid(inValid), .op(op),
        .x(x), .y(y), .z(z),
        .outValid(outValid), .sumM(sumM), .sumE(sumE), .sticky(sticky)
    );

    always #20 clk = ~clk;

    // watchdog
    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("timeout: run still going after %0d cycles", cycleLimit);
            $display("Simulation FAILED");
            $finish;
        end
    end

    ////////////////////
    // reference model
    ////////////////////

    function automatic resultT refFma(input fmaPkg::fmaOp o, input logic [oW-1:0] a,
                                      input logic [oW-1:0] b, input logic [oW-1:0] c);
        longint          xe;
        longint          ye;
        longint          ze;
        longint          cnt;
        longint          expV;
        longint unsigned xm;
        longint unsigned ym;
        longint unsigned zm;
        longint unsigned field;
        longint unsigned sum;
        bit              xZ;
        bit              yZ;
        bit              zZ;
        bit              killP;
        bit              killA;
        bit              st;
        resultT          r;
        // exponent fields, sign bits play no part
        xe = a[oW-2:nf];
        ye = b[oW-2:nf];
        ze = c[oW-2:nf];
        xm = (xe == 0) ? 64'd0 : (64'd1 << nf) + a[nf-1:0];
        ym = (ye == 0) ? 64'd0 : (64'd1 << nf) + b[nf-1:0];
        zm = (ze == 0) ? 64'd0 : (64'd1 << nf) + c[nf-1:0];
        // add means y = 1.0, mul means z = 0
        if (o == fmaPkg::opAdd) begin
            ye = bias;
            ym = 64'd1 << nf;
        end
        if (o == fmaPkg::opMul) begin
            ze = 0;
            zm = 0;
        end
        xZ = (xe == 0);
        yZ = (ye == 0);
        zZ = (ze == 0);
        cnt   = xe + ye - bias + nf + 2 - ze;
        killP = (cnt < 0 && !zZ) || xZ || yZ;
        killA = cnt > 3 * nf + 4;
        if (killP) begin
            field = zm << (2 * nf + 2);
            st    = !(xZ || yZ);
        end else if (killA) begin
            field = 0;
            st    = !zZ;
        end else if (cnt < 0) begin
            // only reachable with z zero, nothing to shift
            field = 0;
            st    = 1'b0;
        end else begin
            field = (zm << (3 * nf + 4)) >> cnt;
            st    = (field & ((64'd1 << nf) - 1)) != 0;
        end
        sum  = (field >> nf) + (killP ? 64'd0 : (xm * ym) << 2);
        expV = killP ? ze : xe + ye - bias;
        r.m  = sum[sW-1:0];
        r.e  = expV[eW-1:0];
        r.s  = st;
        return r;
    endfunction

    ////////////////////
    // checking
    ////////////////////

    task automatic checkValue(input string what, input int id,
                              input logic [63:0] got, input logic [63:0] want);
        checkCount++;
        if (got !== want) begin
            $display("ERR %0t: op %0d %s is 0x%0h, expected 0x%0h", $time, id, what, got, want);
            errCount++;
        end
    endtask

    // outputs are sampled at the falling edge, half a cycle after they settle
    always @(negedge clk) begin
        resultT want;
        int     id;
        if (!rstN) begin
            if (outValid === 1'b1) begin
                $display("outValid went high during reset at %0t", $time);
                errCount++;
            end
        end else begin
            checkValue("outValid", opCount, outValid, validHist[2]);
            if (outValid === 1'b1) begin
                if (expQ.size() == 0) begin
                    $display("result came out at %0t with no operation outstanding", $time);
                    errCount++;
                end else begin
                    want = expQ.pop_front();
                    id   = idQ.pop_front();
                    checkValue("sumM", id, sumM, want.m);
                    checkValue("sumE", id, sumE, want.e);
                    checkValue("sticky", id, sticky, want.s);
                end
            end
        end
        validHist = {validHist[1:0], inValid};
    end

    ////////////////////
    // stimulus helpers
    ////////////////////

    function automatic int randRange(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    // random sign and fraction, chosen exponent field
    function automatic logic [oW-1:0] packOp(input int e);
        logic [oW-1:0] r;
        r = {1'($random(seed)), ne'(e), nf'($random(seed))};
        return r;
    endfunction

    task automatic issueOp(input fmaPkg::fmaOp o, input logic [oW-1:0] a,
                           input logic [oW-1:0] b, input logic [oW-1:0] c);
        @(posedge clk);
        inValid <= 1'b1;
        op      <= o;
        x       <= a;
        y       <= b;
        z       <= c;
        expQ.push_back(refFma(o, a, b, c));
        idQ.push_back(opCount);
        opCount++;
    endtask

    // idle the input and wait for the pipe to empty
    task automatic finishTest(input string name, input int nOps);
        @(posedge clk);
        inValid <= 1'b0;
        while (expQ.size() != 0) begin
            @(posedge clk);
        end
        $display("test %-10s %3d ops, %0d errors", name, nOps, errCount - testErrBase);
        testErrBase = errCount;
    endtask

    ////////////////////
    // tests
    ////////////////////

    task automatic backToBackTest();
        for (int i = 0; i < 20; i++) begin
            issueOp(fmaPkg::opFma, oW'($random(seed)), oW'($random(seed)), oW'($random(seed)));
        end
        finishTest("latency", 20);
    endtask

    // product exponent above ze, addend lands inside the shift range
    task automatic shiftedTest();
        int ex;
        int ey;
        int ez;
        for (int i = 0; i < 16; i++) begin
            do begin
                ex = randRange(1, maxE);
                ey = randRange(1, maxE);
                ez = ex + ey - bias + nf + 2 - randRange(0, 3 * nf + 4);
            end while (ez < 1 || ez > maxE);
            issueOp(fmaPkg::opFma, packOp(ex), packOp(ey), packOp(ez));
        end
        finishTest("shifted", 16);
    endtask

    task automatic killTest();
        // z far below the product
        for (int i = 0; i < 4; i++) begin
            issueOp(fmaPkg::opFma, packOp(randRange(26, maxE)), packOp(randRange(26, maxE)),
                    packOp(randRange(1, 3)));
        end
        // z far above the product
        for (int i = 0; i < 4; i++) begin
            issueOp(fmaPkg::opFma, packOp(randRange(1, 5)), packOp(randRange(1, 5)),
                    packOp(randRange(25, maxE)));
        end
        finishTest("kill", 8);
    endtask

    task automatic zeroTest();
        issueOp(fmaPkg::opFma, packOp(0), packOp(randRange(1, maxE)), packOp(randRange(1, maxE)));
        issueOp(fmaPkg::opFma, packOp(0), packOp(randRange(1, maxE)), packOp(randRange(1, maxE)));
        issueOp(fmaPkg::opFma, packOp(randRange(1, maxE)), packOp(0), packOp(randRange(1, maxE)));
        issueOp(fmaPkg::opFma, packOp(randRange(1, maxE)), packOp(0), packOp(randRange(1, maxE)));
        // product kept, nothing to add
        issueOp(fmaPkg::opFma, packOp(randRange(10, 20)), packOp(randRange(10, 20)), packOp(0));
        issueOp(fmaPkg::opFma, packOp(0), packOp(0), packOp(0));
        finishTest("zeros", 6);
    endtask

    task automatic opcodeTest();
        fmaPkg::fmaOp o;
        for (int i = 0; i < 30; i++) begin
            o = fmaPkg::fmaOp'(2'(randRange(0, 2)));
            issueOp(o, oW'($random(seed)), oW'($random(seed)), oW'($random(seed)));
        end
        finishTest("opcodes", 30);
    endtask

    initial begin
        seed    = 32'h84ad;
        rstN    = 1'b0;
        inValid = 1'b0;
        op      = fmaPkg::opFma;
        x       = '0;
        y       = '0;
        z       = '0;
        repeat (10) @(posedge clk);
        rstN <= 1'b1;
        backToBackTest();
        shiftedTest();
        killTest();
        zeroTest();
        opcodeTest();
        repeat (4) @(posedge clk);
        if (expQ.size() != 0) begin
            $display("%0d expected results never came out of the pipeline", expQ.size());
            errCount++;
        end
        $display("tests %0d, operations %0d, checks %0d, errors %0d",
                 numTests, opCount, checkCount, errCount);
        if (errCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/fmaTb_sva.sv
`default_nettype none

module fmaTbSva #(
    parameter int ne = fmaPkg::NE
) (
    input logic                          clk,
    input logic                          rstN,
    input logic                          inValid,
    input logic                          outValid,
    input logic [fmaPkg::expW(ne)-1:0]   sumE,
    input logic [ne-1:0]                 xe,
    input logic [ne-1:0]                 ye,
    input logic [ne-1:0]                 ze
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int eW   = fmaPkg::expW(ne);
    localparam int bias = (1 << (ne - 1)) - 1;

    // both candidate frame exponents of the operation at the input
    logic [eW-1:0] prodExp;
    logic [eW-1:0] addExp;

    assign prodExp = {2'b00, xe} + {2'b00, ye} - eW'(bias);
    assign addExp  = {2'b00, ze};

    // a reset cycle clears the valid pipe
    resetLow: assert property (@(posedge clk) !rstN |=> !outValid)
        else $error("outValid high right after a reset cycle");

    latency: assert property (@(posedge clk) disable iff (!rstN)
        outValid == $past(inValid, 3))
        else $error("outValid does not follow inValid by three cycles");

    // result frame is either z or the product
    expFrame: assert property (@(posedge clk) disable iff (!rstN)
        outValid |-> (sumE == $past(addExp, 3) || sumE == $past(prodExp, 3)))
        else $error("sumE matches neither ze nor the product exponent");

endmodule

bind fmaTop fmaTbSva #(.ne(ne)) u_fmaTbSva (
    .clk(clk), .rstN(rstN), .inValid(inValid), .outValid(outValid),
    .sumE(sumE), .xe(xe), .ye(ye), .ze(ze)
);

`default_nettype wire

// File: build.f
common/fmaPkg.sv
src/fmaUnpack.sv
fma/fmaMult.sv
src/fmaStage.sv
fma/fmaAlign.sv
fma/fmaAdd.sv
src/fmaTop.sv
bench/fmaTb_sva.sv
bench/fmaTb.sv

// File: common/fmaPkg.sv
`default_nettype none

package fmaPkg;

    // default format is half precision
    localparam int NE = 5;
    localparam int NF = 10;

    // operation select, later stages only see the substituted operands
    typedef enum logic [1:0] {
        opFma = 2'd0,
        opMul = 2'd1,
        opAdd = 2'd2
    } fmaOp;

    ////////////////////
    // width helpers
    ////////////////////

    // exponent bias, 2^(ne-1)-1
    function automatic int biasOf(input int ne);
        return (1 << (ne - 1)) - 1;
    endfunction

    // raw operand: sign, exponent field, fraction field
    function automatic int opW(input int ne, input int nf);
        return 1 + ne + nf;
    endfunction

    // significand with the hidden one
    function automatic int sigW(input int nf);
        return nf + 1;
    endfunction

    // full product of two significands
    function automatic int prodW(input int nf);
        return 2 * nf + 2;
    endfunction

    // aligned addend, product frame plus the bits above it
    function automatic int addW(input int nf);
        return 3 * nf + 5;
    endfunction

    // sum gets one carry bit over the addend
    function automatic int sumW(input int nf);
        return 3 * nf + 6;
    endfunction

    // signed exponent and shift count
    function automatic int expW(input int ne);
        return ne + 2;
    endfunction

endpackage

`default_nettype wire

// File: fma/fmaAdd.sv
`default_nettype none

module fmaAdd #(
    parameter int ne = fmaPkg::NE,
    parameter int nf = fmaPkg::NF
) (
    input  logic                           clk,
    input  logic                           rstN,
    input  logic                           sValid,
    input  logic [fmaPkg::addW(nf)-1:0]    am,
    input  logic                           aSticky,
    input  logic                           killProd,
    input  logic [fmaPkg::prodW(nf)-1:0]   pm,
    input  logic [ne-1:0]                  xe,
    input  logic [ne-1:0]                  ye,
    input  logic [ne-1:0]                  ze,
    output logic                           outValid,
    output logic [fmaPkg::sumW(nf)-1:0]    sumM,
    output logic [fmaPkg::expW(ne)-1:0]    sumE,
    output logic                           sticky
);

    localparam int bias = fmaPkg::biasOf(ne);
    localparam int sW   = fmaPkg::sumW(nf);
    localparam int eW   = fmaPkg::expW(ne);

    logic [sW-1:0] prodPos;
    logic [sW-1:0] sumNext;
    logic [eW-1:0] expNext;

    // product two bits above the lsb, the two bits under it are guard room
    //   | nf+2 zeros | pm | 00 |
    assign prodPos = killProd ? '0 : {{(nf + 2){1'b0}}, pm, 2'b00};

    // extra top bit catches the carry out of the addend frame
    assign sumNext = {1'b0, am} + prodPos;

    // frame exponent: z when the product is gone, else the product exponent
    assign expNext = killProd ? {2'b00, ze}
                              : {2'b00, xe} + {2'b00, ye} - eW'(bias);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else begin
            outValid <= sValid;
        end
    end

    // result goes out unnormalized and unrounded
    always_ff @(posedge clk) begin
        sumM   <= sumNext;
        sumE   <= expNext;
        sticky <= aSticky;
    end

endmodule

`default_nettype wire

// File: fma/fmaAlign.sv
`default_nettype none

module fmaAlign #(
    parameter int ne = fmaPkg::NE,
    parameter int nf = fmaPkg::NF
) (
    input  logic [ne-1:0]                  xe,
    input  logic [ne-1:0]                  ye,
    input  logic [ne-1:0]                  ze,
    input  logic [fmaPkg::sigW(nf)-1:0]    zm,
    input  logic                           xZero,
    input  logic                           yZero,
    input  logic                           zZero,
    output logic [fmaPkg::addW(nf)-1:0]    am,
    output logic                           aSticky,
    output logic                           killProd
);

    localparam int bias   = fmaPkg::biasOf(ne);
    localparam int cntW   = fmaPkg::expW(ne);
    // shift field, addend frame plus nf sticky bits below it
    localparam int fieldW = 4 * nf + 5;

    // shift count in Q(ne+2.0)
    logic [cntW-1:0]   aCnt;
    logic              killZ;
    // shifter input and output, U(nf+5.3nf) with sticky bits at the bottom
    logic [fieldW-1:0] zmPreshifted;
    logic [fieldW-1:0] zmShifted;

    ////////////////////
    // shift count
    ////////////////////

    // distance from the addend to the product frame
    //   negative: z is bigger than the product
    //   positive: product is bigger, shift z right
    // computed from the raw exponents and not from the product exponent,
    // this keeps the adder chain in front of the shifter short
    assign aCnt = {2'b00, xe} + {2'b00, ye} - cntW'(bias) + cntW'(nf + 2) - {2'b00, ze};

    // product far below the addend, or no product at all
    assign killProd = (aCnt[cntW-1] & ~zZero) | xZero | yZero;

    // addend shifted past the two guard bits under the product
    assign killZ = $signed(aCnt) > $signed(cntW'(3 * nf + 4));

    ////////////////////
    // shifter
    ////////////////////

    // addend starts at the top of the field
    //   | zm | 3nf+4 zeros |
    assign zmPreshifted = {zm, {(3 * nf + 4){1'b0}}};

    always_comb begin
        if (killProd) begin
            // addend sits just above the product frame
            //   | nf+2 zeros | zm | 2nf+2 zeros |
            zmShifted = {{(nf + 2){1'b0}}, zm, {(2 * nf + 2){1'b0}}};
            // a dropped nonzero product only shows up as sticky
            aSticky   = ~(xZero | yZero);
        end else if (killZ) begin
            // addend below the guard bits, all of it goes into sticky
            zmShifted = '0;
            aSticky   = ~zZero;
        end else begin
            // normal case, aCnt is 0..3nf+4 here
            zmShifted = zmPreshifted >> aCnt;
            aSticky   = |zmShifted[nf-1:0];
        end
    end

    // drop the sticky bits, the rest is the aligned addend
    assign am = zmShifted[fieldW-1:nf];

endmodule

`default_nettype wire

// File: fma/fmaMult.sv
`default_nettype none

module fmaMult #(
    parameter int ne = fmaPkg::NE,
    parameter int nf = fmaPkg::NF
) (
    input  logic                           clk,
    input  logic                           rstN,
    input  logic                           inValid,
    input  logic [ne-1:0]                  xe,
    input  logic [ne-1:0]                  ye,
    input  logic [ne-1:0]                  ze,
    input  logic [fmaPkg::sigW(nf)-1:0]    xm,
    input  logic [fmaPkg::sigW(nf)-1:0]    ym,
    input  logic [fmaPkg::sigW(nf)-1:0]    zm,
    input  logic                           xZero,
    input  logic                           yZero,
    input  logic                           zZero,
    output logic                           mValid,
    output logic [fmaPkg::prodW(nf)-1:0]   pm,
    output logic [ne-1:0]                  mXe,
    output logic [ne-1:0]                  mYe,
    output logic [ne-1:0]                  mZe,
    output logic [fmaPkg::sigW(nf)-1:0]    mZm,
    output logic                           mXZero,
    output logic                           mYZero,
    output logic                           mZZero
);

    // significand product, U(2.2nf) format
    logic [fmaPkg::prodW(nf)-1:0] prod;

    assign prod = xm * ym;

    // valid is the only control state
    always_ff @(posedge clk) begin
        if (!rstN) begin
            mValid <= 1'b0;
        end else begin
            mValid <= inValid;
        end
    end

    // product and the fields the alignment needs later
    always_ff @(posedge clk) begin
        pm     <= prod;
        mXe    <= xe;
        mYe    <= ye;
        mZe    <= ze;
        mZm    <= zm;
        mXZero <= xZero;
        mYZero <= yZero;
        mZZero <= zZero;
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# builds and runs the fma testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module fmaTb -f build.f -o fmaSim

./obj_dir/fmaSim | tee sim.log

# a run that stops early never prints the closing lines
if grep -q "Simulation FAILED" sim.log || ! grep -q "Simulation PASSED" sim.log; then
    echo "run failed, see sim.log"
    exit 1
fi
echo "run passed"

// File: src/fmaStage.sv
`default_nettype none

module fmaStage #(
    parameter int ne = fmaPkg::NE,
    parameter int nf = fmaPkg::NF
) (
    input  logic                           clk,
    input  logic                           rstN,
    input  logic                           mValid,
    input  logic [fmaPkg::prodW(nf)-1:0]   pm,
    input  logic [ne-1:0]                  mXe,
    input  logic [ne-1:0]                  mYe,
    input  logic [ne-1:0]                  mZe,
    input  logic [fmaPkg::sigW(nf)-1:0]    mZm,
    input  logic                           mXZero,
    input  logic                           mYZero,
    input  logic                           mZZero,
    output logic                           sValid,
    output logic [fmaPkg::prodW(nf)-1:0]   sPm,
    output logic [ne-1:0]                  sXe,
    output logic [ne-1:0]                  sYe,
    output logic [ne-1:0]                  sZe,
    output logic [fmaPkg::sigW(nf)-1:0]    sZm,
    output logic                           sXZero,
    output logic                           sYZero,
    output logic                           sZZero
);

    // cuts the multiplier off from the alignment shifter,
    // the shift count path starts fresh from flops here
    always_ff @(posedge clk) begin
        if (!rstN) begin
            sValid <= 1'b0;
        end else begin
            sValid <= mValid;
        end
    end

    always_ff @(posedge clk) begin
        sPm    <= pm;
        sXe    <= mXe;
        sYe    <= mYe;
        sZe    <= mZe;
        sZm    <= mZm;
        sXZero <= mXZero;
        sYZero <= mYZero;
        sZZero <= mZZero;
    end

endmodule

`default_nettype wire

// File: src/fmaTop.sv
`default_nettype none

module fmaTop #(
    parameter int ne = fmaPkg::NE,
    parameter int nf = fmaPkg::NF
) (
    input  logic                              clk,
    input  logic                              rstN,
    input  logic                              inValid,
    input  fmaPkg::fmaOp                      op,
    input  logic [fmaPkg::opW(ne, nf)-1:0]    x,
    input  logic [fmaPkg::opW(ne, nf)-1:0]    y,
    input  logic [fmaPkg::opW(ne, nf)-1:0]    z,
    output logic                              outValid,
    output logic [fmaPkg::sumW(nf)-1:0]       sumM,
    output logic [fmaPkg::expW(ne)-1:0]       sumE,
    output logic                              sticky
);

    // unpacked operands
    logic [ne-1:0]                 xe, ye, ze;
    logic [fmaPkg::sigW(nf)-1:0]   xm, ym, zm;
    logic                          xZero, yZero, zZero;

    // multiply stage
    logic                          mValid;
    logic [fmaPkg::prodW(nf)-1:0]  pm;
    logic [ne-1:0]                 mXe, mYe, mZe;
    logic [fmaPkg::sigW(nf)-1:0]   mZm;
    logic                          mXZero, mYZero, mZZero;

    // pipeline register stage
    logic                          sValid;
    logic [fmaPkg::prodW(nf)-1:0]  sPm;
    logic [ne-1:0]                 sXe, sYe, sZe;
    logic [fmaPkg::sigW(nf)-1:0]   sZm;
    logic                          sXZero, sYZero, sZZero;

    // alignment
    logic [fmaPkg::addW(nf)-1:0]   am;
    logic                          aSticky;
    logic                          killProd;

    fmaUnpack #(.ne(ne), .nf(nf)) u_fmaUnpack (
        .op(op), .x(x), .y(y), .z(z),
        .xe(xe), .ye(ye), .ze(ze),
        .xm(xm), .ym(ym), .zm(zm),
        .xZero(xZero), .yZero(yZero), .zZero(zZero)
    );

    // cycle 1
    fmaMult #(.ne(ne), .nf(nf)) u_fmaMult (
        .clk(clk), .rstN(rstN), .inValid(inValid),
        .xe(xe), .ye(ye), .ze(ze),
        .xm(xm), .ym(ym), .zm(zm),
        .xZero(xZero), .yZero(yZero), .zZero(zZero),
        .mValid(mValid), .pm(pm),
        .mXe(mXe), .mYe(mYe), .mZe(mZe), .mZm(mZm),
        .mXZero(mXZero), .mYZero(mYZero), .mZZero(mZZero)
    );

    // cycle 2
    fmaStage #(.ne(ne), .nf(nf)) u_fmaStage (
        .clk(clk), .rstN(rstN), .mValid(mValid), .pm(pm),
        .mXe(mXe), .mYe(mYe), .mZe(mZe), .mZm(mZm),
        .mXZero(mXZero), .mYZero(mYZero), .mZZero(mZZero),
        .sValid(sValid), .sPm(sPm),
        .sXe(sXe), .sYe(sYe), .sZe(sZe), .sZm(sZm),
        .sXZero(sXZero), .sYZero(sYZero), .sZZero(sZZero)
    );

    fmaAlign #(.ne(ne), .nf(nf)) u_fmaAlign (
        .xe(sXe), .ye(sYe), .ze(sZe), .zm(sZm),
        .xZero(sXZero), .yZero(sYZero), .zZero(sZZero),
        .am(am), .aSticky(aSticky), .killProd(killProd)
    );

    // cycle 3, result registers
    fmaAdd #(.ne(ne), .nf(nf)) u_fmaAdd (
        .clk(clk), .rstN(rstN), .sValid(sValid),
        .am(am), .aSticky(aSticky), .killProd(killProd),
        .pm(sPm), .xe(sXe), .ye(sYe), .ze(sZe),
        .outValid(outValid), .sumM(sumM), .sumE(sumE), .sticky(sticky)
    );

endmodule

`default_nettype wire

// File: src/fmaUnpack.sv
`default_nettype none

module fmaUnpack #(
    parameter int ne = fmaPkg::NE,
    parameter int nf = fmaPkg::NF
) (
    input  fmaPkg::fmaOp                       op,
    input  logic [fmaPkg::opW(ne, nf)-1:0]     x,
    input  logic [fmaPkg::opW(ne, nf)-1:0]     y,
    input  logic [fmaPkg::opW(ne, nf)-1:0]     z,
    output logic [ne-1:0]                      xe,
    output logic [ne-1:0]                      ye,
    output logic [ne-1:0]                      ze,
    output logic [fmaPkg::sigW(nf)-1:0]        xm,
    output logic [fmaPkg::sigW(nf)-1:0]        ym,
    output logic [fmaPkg::sigW(nf)-1:0]        zm,
    output logic                               xZero,
    output logic                               yZero,
    output logic                               zZero
);

    localparam int bias = fmaPkg::biasOf(ne);

    // raw fields, the sign bit on top is not looked at
    logic [ne-1:0] xField, yField, zField;
    logic [nf-1:0] xFrac, yFrac, zFrac;

    assign xField = x[ne+nf-1:nf];
    assign yField = y[ne+nf-1:nf];
    assign zField = z[ne+nf-1:nf];
    assign xFrac  = x[nf-1:0];
    assign yFrac  = y[nf-1:0];
    assign zFrac  = z[nf-1:0];

    // x is never substituted
    assign xe    = xField;
    assign xZero = (xField == '0);
    // zero exponent field means the value zero, so no hidden one and no fraction
    assign xm    = xZero ? '0 : {1'b1, xFrac};

    always_comb begin
        // y becomes 1.0 for add
        if (op == fmaPkg::opAdd) begin
            ye    = ne'(bias);
            ym    = {1'b1, {nf{1'b0}}};
            yZero = 1'b0;
        end else begin
            ye    = yField;
            yZero = (yField == '0);
            ym    = yZero ? '0 : {1'b1, yFrac};
        end

        // z becomes zero for mul
        if (op == fmaPkg::opMul) begin
            ze    = '0;
            zm    = '0;
            zZero = 1'b1;
        end else begin
            ze    = zField;
            zZero = (zField == '0);
            zm    = zZero ? '0 : {1'b1, zFrac};
        end
    end

endmodule

`default_nettype wire
